//--- include/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// register byte offsets on the 4-bit bus address
`define UART_REG_DATA    4'h0
`define UART_REG_STATUS  4'h4
`define UART_REG_CTRL    4'h8
`define UART_REG_BAUD    4'hC

// CTRL write-only clear bits, above the line config field
`define UART_CTRL_TXCLR  9
`define UART_CTRL_RXCLR  10

// fifo entries, transmit and receive alike
`define UART_FIFO_DEPTH     8
`define UART_TICKS_PER_BIT  16  // baud ticks per serial bit

`endif

//--- verilog/uartBusPkg.sv
package uartBusPkg;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	// master to slave, no strobes
	typedef struct packed {
		logic        awvalid;
		logic [3:0]  awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic        bready;
		logic        arvalid;
		logic [3:0]  araddr;
		logic        rready;
	} axilReq_t;

	// slave to master
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axilRsp_t;

	// STATUS word with txEmpty in bit 0
	typedef struct packed {
		logic txBusy;
		logic frameErr;
		logic parityErr;
		logic overrun;
		logic rxFull;
		logic rxEmpty;
		logic txFull;
		logic txEmpty;
	} uartStatus_t;

endpackage

//--- verilog/uartLinePkg.sv
package uartLinePkg;

	// parity select codes, anything not listed means none
	typedef enum logic [2:0] {
		PAR_NONE  = 3'b000,
		PAR_ODD   = 3'b001,
		PAR_EVEN  = 3'b011,
		PAR_MARK  = 3'b101,
		PAR_SPACE = 3'b111
	} parity_e;

	typedef struct packed {
		logic [3:0] wordLength;  // 5..8
		parity_e    parity;
		logic       twoStop;
		logic       txBreak;
	} lineCfg_t;

	// flags above the byte so the packed char maps straight onto DATA
	typedef struct packed {
		logic       breakDet;
		logic       frameErr;
		logic       parityErr;
		logic [7:0] data;
	} rxChar_t;

	// lengths outside 5..7 run as 8 bits
	function automatic logic [3:0] wordLen(input lineCfg_t cfg);
		return (cfg.wordLength inside {4'd5, 4'd6, 4'd7}) ? cfg.wordLength : 4'd8;
	endfunction

	function automatic logic hasParity(input parity_e p);
		return p inside {PAR_ODD, PAR_EVEN, PAR_MARK, PAR_SPACE};
	endfunction

	// expects masked data
	function automatic logic parityBit(input parity_e p, input logic [7:0] d);
		case (p)
			PAR_ODD:   return ~^d;
			PAR_EVEN:  return ^d;
			PAR_SPACE: return 1'b0;
			default:   return 1'b1;  // mark, or a stop bit when parity is off
		endcase
	endfunction

	// keep the low n bits
	function automatic logic [7:0] maskData(input logic [3:0] n, input logic [7:0] d);
		logic [7:0] m;
		m = 8'hFF >> (4'd8 - n);
		return d & m;
	endfunction

endpackage

//--- verilog/uartFifo.sv
`include "uart_macros.svh"
`timescale 1ns/100ps

module uartFifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = `UART_FIFO_DEPTH
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       push,
	input  payload_t                   din,
	input  logic                       pop,
	output payload_t                   dout,
	output logic                       full,
	output logic                       empty,
	output logic [$clog2(DEPTH+1)-1:0] count
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t      mem [DEPTH];
	logic [AW-1:0] wrPtr;
	logic [AW-1:0] rdPtr;
	logic          doPush;
	logic          doPop;

	// wrap at DEPTH, depth need not be a power of two
	function automatic logic [AW-1:0] nextPtr(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full   = count == CW'(DEPTH);
	assign empty  = count == '0;
	assign doPush = push && !full;   // push into full is lost
	assign doPop  = pop && !empty;   // pop of empty does nothing
	assign dout   = mem[rdPtr];      // head shown with no read delay

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // none, or both at once
			endcase
		end
	end

	always_ff @(posedge clk)
		if (doPush)
			mem[wrPtr] <= din;

endmodule

//--- verilog/uartBaudGen.sv
`timescale 1ns/100ps

module uartBaudGen (
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] divisor,
	output logic        baudTick
);
	logic [15:0] cnt;  // counts down to zero

	// one tick every divisor+1 clocks
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt      <= '0;
			baudTick <= 1'b0;
		end else if (cnt == '0) begin
			cnt      <= divisor;  // divisor changes land only here
			baudTick <= 1'b1;
		end else begin
			cnt      <= cnt - 16'd1;
			baudTick <= 1'b0;
		end
	end

endmodule

//--- verilog/uartTx.sv
`include "uart_macros.svh"
`timescale 1ns/100ps

module uartTx (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  baudTick,  // 16x bit rate
	input  uartLinePkg::lineCfg_t cfg,
	input  logic                  cts,
	input  logic                  clear,
	input  logic [7:0]            fifoData,
	input  logic                  fifoEmpty,
	output logic                  fifoPop,
	output logic                  busy,
	output logic                  txd
);
	import uartLinePkg::*;

	localparam int TPB = `UART_TICKS_PER_BIT;

	typedef enum logic {IDLE, CNT} txState_e;

	txState_e    state;
	logic [7:0]  cnt;        // ticks into the frame
	logic [11:0] shiftReg;   // bit 0 goes out next
	logic [11:0] frame;
	logic [3:0]  wl;
	logic [7:0]  txByte;
	logic        parBit;
	logic [3:0]  frameBits;
	logic [7:0]  lastCnt;
	logic        start;
	logic        bitEnd;

	// ==================================================
	// frame build
	// ==================================================
	assign wl     = wordLen(cfg);
	assign txByte = maskData(wl, fifoData);  // mask before parity
	assign parBit = parityBit(cfg.parity, txByte);

	// stop bits and idle fill are the ones above the parity slot
	always_comb begin
		if (cfg.txBreak)
			frame = '0;  // whole frame low, stop bits too
		else begin
			case (wl)
				4'd5:    frame = {5'b11111, parBit, txByte[4:0], 1'b0};
				4'd6:    frame = {4'b1111, parBit, txByte[5:0], 1'b0};
				4'd7:    frame = {3'b111, parBit, txByte[6:0], 1'b0};
				default: frame = {2'b11, parBit, txByte, 1'b0};
			endcase
		end
	end

	// start + data + parity + stops
	assign frameBits = 4'd1 + wl + 4'(hasParity(cfg.parity)) + (cfg.twoStop ? 4'd2 : 4'd1);
	assign lastCnt   = 8'(frameBits * TPB - 1);

	assign bitEnd  = cnt[$clog2(TPB)-1:0] == '1;  // last tick of a bit
	assign start   = baudTick && state == IDLE && !clear && (cfg.txBreak || (!fifoEmpty && cts));
	assign fifoPop = start && !cfg.txBreak;      // break leaves queued bytes alone

	// ==================================================
	// idle / counting machine
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			state    <= IDLE;
			cnt      <= '0;
			shiftReg <= '1;
		end else begin
			case (state)
				IDLE: begin
					cnt <= '0;
					if (start) begin
						state    <= CNT;
						shiftReg <= frame;  // head byte taken on the pop edge
					end else if (!cfg.txBreak) begin
						shiftReg <= '1;     // back to mark once break drops
					end
				end
				CNT: begin
					if (baudTick) begin
						cnt <= cnt + 8'd1;
						if (bitEnd)
							shiftReg <= {~cfg.txBreak, shiftReg[11:1]};  // LSB first
						if (cnt == lastCnt)
							state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// output flop, busy kept in step with txd
	always_ff @(posedge clk) begin
		if (rst) begin
			txd  <= 1'b1;
			busy <= 1'b0;
		end else begin
			txd  <= shiftReg[0];
			busy <= state == CNT;
		end
	end

endmodule

//--- verilog/uartRx.sv
`include "uart_macros.svh"
`timescale 1ns/100ps

module uartRx (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  baudTick,
	input  uartLinePkg::lineCfg_t cfg,
	input  logic                  rxd,     // async line
	output logic                  push,
	output uartLinePkg::rxChar_t  rxChar
);
	import uartLinePkg::*;

	localparam int TPB = `UART_TICKS_PER_BIT;
	localparam int TW  = $clog2(TPB);

	typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} rxState_e;

	rxState_e      state;
	logic [1:0]    rxSync;    // two flop synchronizer
	logic          rxPrev;    // for the falling edge
	logic          rxIn;
	logic [TW-1:0] tickCnt;
	logic [2:0]    bitIdx;
	logic [7:0]    dataReg;
	logic          parRx;
	logic [3:0]    wl;
	logic          sample;

	assign rxIn   = rxSync[1];
	assign wl     = wordLen(cfg);
	assign sample = baudTick && tickCnt == TW'(TPB - 1);  // mid bit, 16 ticks on

	always_ff @(posedge clk) begin
		if (rst) begin
			rxSync <= 2'b11;
			rxPrev <= 1'b1;
		end else begin
			rxSync <= {rxSync[0], rxd};
			rxPrev <= rxIn;
		end
	end

	// ==================================================
	// character FSM
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IDLE;
			tickCnt <= '0;
			bitIdx  <= '0;
			push    <= 1'b0;
		end else begin
			push <= 1'b0;
			if (baudTick)
				tickCnt <= tickCnt + 1'b1;  // wraps every bit time
			case (state)
				IDLE: begin
					tickCnt <= '0;
					if (rxPrev && !rxIn)
						state <= START;
				end
				START: begin
					if (baudTick && tickCnt == TW'(TPB / 2 - 1)) begin
						tickCnt <= '0;             // realign on mid start bit
						bitIdx  <= '0;
						state   <= rxIn ? IDLE : DATA;  // high again means a glitch
					end
				end
				DATA: begin
					if (sample) begin
						bitIdx <= bitIdx + 3'd1;
						if (bitIdx == 3'(wl - 4'd1))
							state <= hasParity(cfg.parity) ? PARITY : STOP;
					end
				end
				PARITY: begin
					if (sample)
						state <= STOP;
				end
				STOP: begin
					if (sample) begin
						push  <= 1'b1;  // one stop checked, a second one reads as idle
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// assembly and checks
	always_ff @(posedge clk) begin
		if (state == START) begin
			dataReg <= '0;    // unused upper bits stay zero
			parRx   <= 1'b0;  // zero without parity so break check still holds
		end else if (sample && state == DATA) begin
			dataReg[bitIdx] <= rxIn;
		end else if (sample && state == PARITY) begin
			parRx <= rxIn;
		end
		if (sample && state == STOP) begin
			rxChar.data      <= dataReg;
			rxChar.parityErr <= hasParity(cfg.parity) && parRx != parityBit(cfg.parity, dataReg);
			rxChar.frameErr  <= !rxIn;  // stop must be high
			rxChar.breakDet  <= dataReg == '0 && !parRx && !rxIn;
		end
	end

endmodule

//--- verilog/uartRegs.sv
`include "uart_macros.svh"
`timescale 1ns/100ps

module uartRegs (
	input  logic                  clk,
	input  logic                  rst,
	input  uartBusPkg::axilReq_t  axilReq,
	output uartBusPkg::axilRsp_t  axilRsp,
	output logic                  txPush,
	output logic [7:0]            txData,
	input  logic                  txFull,
	input  logic                  txEmpty,
	input  logic                  txBusy,
	output logic                  txClear,
	output logic                  rxPop,
	input  uartLinePkg::rxChar_t  rxHead,
	input  logic                  rxEmpty,
	input  logic                  rxFull,
	input  logic                  rxPush,
	output logic                  rxClear,
	output uartLinePkg::lineCfg_t cfg,
	output logic [15:0]           divisor
);
	import uartBusPkg::*;
	import uartLinePkg::*;

	logic        live;     // low for the first cycle out of reset
	logic        wrHs;
	logic        rdHs;
	logic        ctrlWr;
	logic        bvalid;
	logic        rvalid;
	logic [31:0] rdata;
	logic [31:0] rdMux;
	logic        stickyOverrun;
	logic        stickyParity;
	logic        stickyFrame;
	uartStatus_t status;

	// ==================================================
	// AXI4-Lite channels
	// ==================================================
	// aw and w taken together, never while a response is pending
	assign wrHs = live && axilReq.awvalid && axilReq.wvalid && !bvalid;
	assign rdHs = live && axilReq.arvalid && !rvalid;

	always_comb begin
		axilRsp.awready = wrHs;
		axilRsp.wready  = wrHs;
		axilRsp.bvalid  = bvalid;
		axilRsp.bresp   = AXI_RESP_OKAY;  // no error responses
		axilRsp.arready = live && !rvalid;
		axilRsp.rvalid  = rvalid;
		axilRsp.rdata   = rdata;
		axilRsp.rresp   = AXI_RESP_OKAY;
	end

	// fifo strobes fire on the handshake cycle
	assign txPush  = wrHs && axilReq.awaddr == `UART_REG_DATA;  // full fifo drops it
	assign txData  = axilReq.wdata[7:0];
	assign ctrlWr  = wrHs && axilReq.awaddr == `UART_REG_CTRL;
	assign txClear = ctrlWr && axilReq.wdata[`UART_CTRL_TXCLR];
	assign rxClear = ctrlWr && axilReq.wdata[`UART_CTRL_RXCLR];
	assign rxPop   = rdHs && axilReq.araddr == `UART_REG_DATA;

	// ==================================================
	// status and read mux
	// ==================================================
	always_comb begin
		status.txEmpty   = txEmpty;
		status.txFull    = txFull;
		status.rxEmpty   = rxEmpty;
		status.rxFull    = rxFull;
		status.overrun   = stickyOverrun;
		status.parityErr = stickyParity || (!rxEmpty && rxHead.parityErr);  // head counts too
		status.frameErr  = stickyFrame || (!rxEmpty && rxHead.frameErr);
		status.txBusy    = txBusy;
	end

	always_comb begin
		case (axilReq.araddr)
			`UART_REG_DATA:   rdMux = rxEmpty ? '0 : 32'(rxHead);  // flags in 10:8
			`UART_REG_STATUS: rdMux = 32'(status);
			`UART_REG_CTRL:   rdMux = 32'(cfg);
			`UART_REG_BAUD:   rdMux = 32'(divisor);
			default:          rdMux = '0;
		endcase
	end

	always_ff @(posedge clk)
		if (rdHs)
			rdata <= rdMux;  // held until rready

	// ==================================================
	// control state
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			live          <= 1'b0;
			bvalid        <= 1'b0;
			rvalid        <= 1'b0;
			cfg           <= '{wordLength: 4'd8, parity: PAR_NONE, twoStop: 1'b0, txBreak: 1'b0};
			divisor       <= 16'd0;
			stickyOverrun <= 1'b0;
			stickyParity  <= 1'b0;
			stickyFrame   <= 1'b0;
		end else begin
			live <= 1'b1;
			if (wrHs)
				bvalid <= 1'b1;
			else if (axilReq.bready)
				bvalid <= 1'b0;
			if (rdHs)
				rvalid <= 1'b1;
			else if (axilReq.rready)
				rvalid <= 1'b0;
			if (ctrlWr)
				cfg <= lineCfg_t'(axilReq.wdata[8:0]);  // clear bits are not stored
			if (wrHs && axilReq.awaddr == `UART_REG_BAUD)
				divisor <= axilReq.wdata[15:0];
			// STATUS read clears, a set in the same cycle wins
			if (rdHs && axilReq.araddr == `UART_REG_STATUS) begin
				stickyOverrun <= 1'b0;
				stickyParity  <= 1'b0;
				stickyFrame   <= 1'b0;
			end
			if (rxPush && rxFull)
				stickyOverrun <= 1'b1;  // char dropped by the fifo
			if (rxPop && !rxEmpty) begin
				if (rxHead.parityErr)
					stickyParity <= 1'b1;
				if (rxHead.frameErr)
					stickyFrame <= 1'b1;
			end
		end
	end

endmodule

//--- verilog/uartTop.sv
`timescale 1ns/100ps

module uartTop (
	input  logic                 clk,
	input  logic                 rst,
	input  uartBusPkg::axilReq_t axilReq,
	output uartBusPkg::axilRsp_t axilRsp,
	output logic                 txd,
	input  logic                 rxd,
	input  logic                 cts
);
	import uartLinePkg::*;

	lineCfg_t    cfg;
	logic [15:0] divisor;
	logic        baudTick;

	// transmit side
	logic        txPush;
	logic [7:0]  txData;
	logic        txFull;
	logic        txEmpty;
	logic        txBusy;
	logic        txClear;
	logic        txPop;
	logic [7:0]  txHead;

	// receive side
	logic        rxPop;
	rxChar_t     rxHead;
	logic        rxEmpty;
	logic        rxFull;
	logic        rxPush;
	logic        rxClear;
	rxChar_t     rxChar;

	uartRegs uartRegs_inst (
		.clk(clk), .rst(rst), .axilReq(axilReq), .axilRsp(axilRsp),
		.txPush(txPush), .txData(txData), .txFull(txFull), .txEmpty(txEmpty),
		.txBusy(txBusy), .txClear(txClear), .rxPop(rxPop), .rxHead(rxHead),
		.rxEmpty(rxEmpty), .rxFull(rxFull), .rxPush(rxPush), .rxClear(rxClear),
		.cfg(cfg), .divisor(divisor)
	);

	uartBaudGen uartBaudGen_inst (.clk(clk), .rst(rst), .divisor(divisor), .baudTick(baudTick));

	// clear bits act as a one cycle reset of each fifo
	uartFifo #(.payload_t(logic [7:0])) txFifo_inst (
		.clk(clk), .rst(rst | txClear), .push(txPush), .din(txData), .pop(txPop),
		.dout(txHead), .full(txFull), .empty(txEmpty), .count()
	);

	uartFifo #(.payload_t(rxChar_t)) rxFifo_inst (
		.clk(clk), .rst(rst | rxClear), .push(rxPush), .din(rxChar), .pop(rxPop),
		.dout(rxHead), .full(rxFull), .empty(rxEmpty), .count()
	);

	uartTx uartTx_inst (
		.clk(clk), .rst(rst), .baudTick(baudTick), .cfg(cfg), .cts(cts), .clear(txClear),
		.fifoData(txHead), .fifoEmpty(txEmpty), .fifoPop(txPop), .busy(txBusy), .txd(txd)
	);

	uartRx uartRx_inst (
		.clk(clk), .rst(rst), .baudTick(baudTick), .cfg(cfg), .rxd(rxd),
		.push(rxPush), .rxChar(rxChar)
	);

endmodule

//--- verif/uartProps.sv
`timescale 1ns/100ps

module uartProps (
	input logic                  clk,
	input logic                  rst,
	input uartBusPkg::axilReq_t  axilReq,
	input uartBusPkg::axilRsp_t  axilRsp,
	input uartLinePkg::lineCfg_t cfg,
	input logic                  txd,
	input logic                  txBusy,
	input logic                  txPop,
	input logic                  txEmpty
);
	// ==================================================
	// bus handshake rules
	// ==================================================
	bvalidHold: assert property (@(posedge clk) disable iff (rst)
		axilRsp.bvalid && !axilReq.bready |=> axilRsp.bvalid)
		else $error("bvalid dropped before bready");

	rvalidHold: assert property (@(posedge clk) disable iff (rst)
		axilRsp.rvalid && !axilReq.rready |=> axilRsp.rvalid)
		else $error("rvalid dropped before rready");

	noAwWhileB: assert property (@(posedge clk) disable iff (rst)
		axilRsp.bvalid |-> !axilRsp.awready)
		else $error("awready high with a write response pending");

	// ==================================================
	// transmit line
	// ==================================================
	// break edges and frame ends lag txd by up to two clocks
	txdIdleHigh: assert property (@(posedge clk) disable iff (rst)
		!txBusy && !$past(txBusy) && !cfg.txBreak && !$past(cfg.txBreak)
		&& !$past(cfg.txBreak, 2) |-> txd)
		else $error("txd low while the transmitter is idle");

	popNotEmpty: assert property (@(posedge clk) disable iff (rst)
		txPop |-> !txEmpty)
		else $error("transmit fifo popped while empty");

endmodule

bind uartTop uartProps uartProps_inst (
	.clk(clk), .rst(rst), .axilReq(axilReq), .axilRsp(axilRsp), .cfg(cfg),
	.txd(txd), .txBusy(txBusy), .txPop(txPop), .txEmpty(txEmpty)
);

//--- verif/uartTb.sv
`include "uart_macros.svh"
`timescale 1ns/100ps

module uartTb;
	import uartBusPkg::*;
	import uartLinePkg::*;

	localparam int TABLE_LEN = 8;
	localparam int MAX_DIV   = 3;
	localparam int SLOW_DIV  = 'h1234;  // baud readback value, counted out before the table
	localparam int DEPTH     = `UART_FIFO_DEPTH;
	localparam int TPB       = `UART_TICKS_PER_BIT;
	// table frames at worst rate, plus fixed-rate fifo/error/break tests and the slow reload
	localparam int WATCH_CYCLES = (TABLE_LEN + 4 * DEPTH + 40) * 12 * TPB * (MAX_DIV + 1) * 2
		+ SLOW_DIV + 20000;

	typedef struct packed {
		logic [3:0]  wl;
		parity_e     par;
		logic        twoStop;
		logic [15:0] div;
		logic [7:0]  data;
		logic        cts;
	} stim_t;

	logic     clk;
	logic     rst;
	logic     cts;
	logic     lineDrive;   // rxd source while loopback is forced
	axilReq_t req;
	axilRsp_t rsp;
	logic     txd;
	wire      lineWire;
	stim_t    stimTable [TABLE_LEN];
	int       errCount;
	int       testsRun;
	int       testsFailed;

	assign lineWire = txd;  // loopback

	uartTop uartTop_inst (
		.clk(clk), .rst(rst), .axilReq(req), .axilRsp(rsp),
		.txd(txd), .rxd(lineWire), .cts(cts)
	);

	always #5 clk = ~clk;

	initial begin
		repeat (WATCH_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles", WATCH_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	// ==================================================
	// compare tasks
	// ==================================================
	task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errCount++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errCount++;
		end
	endtask

	task automatic checkResp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errCount++;
		end
	endtask

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errCount++;
		end
	endtask

	task automatic checkStatus(input string name, input uartStatus_t got, input uartStatus_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errCount++;
		end
	endtask

	task automatic checkChar(input string name, input rxChar_t got, input rxChar_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errCount++;
		end
	endtask

	// ==================================================
	// AXI4-Lite driver
	// ==================================================
	task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data);
		int waitCnt;
		waitCnt = 0;
		@(negedge clk);
		req.awvalid = 1'b1;
		req.wvalid  = 1'b1;
		req.awaddr  = addr;
		req.wdata   = data;
		#1;  // let awready settle
		while (!rsp.awready && waitCnt < 100) begin
			@(negedge clk);
			#1;
			waitCnt++;
		end
		if (!(rsp.awready && rsp.wready)) begin
			$display("write to offset %h was never accepted", addr);
			errCount++;
		end
		@(negedge clk);
		req.awvalid = 1'b0;
		req.wvalid  = 1'b0;
		@(negedge clk);  // one cycle with bready low, bvalid must hold
		if (!rsp.bvalid) begin
			$display("write to offset %h got no response", addr);
			errCount++;
		end
		checkResp("bresp", rsp.bresp, AXI_RESP_OKAY);
		req.bready = 1'b1;
		@(negedge clk);
		req.bready = 1'b0;
	endtask

	task automatic axiRead(input logic [3:0] addr, output logic [31:0] data);
		int waitCnt;
		waitCnt = 0;
		@(negedge clk);
		req.arvalid = 1'b1;
		req.araddr  = addr;
		#1;
		while (!rsp.arready && waitCnt < 100) begin
			@(negedge clk);
			#1;
			waitCnt++;
		end
		@(negedge clk);
		req.arvalid = 1'b0;
		@(negedge clk);  // one cycle with rready low, rvalid must hold
		if (!rsp.rvalid) begin
			$display("read from offset %h returned no data", addr);
			errCount++;
		end
		checkResp("rresp", rsp.rresp, AXI_RESP_OKAY);
		data = rsp.rdata;
		req.rready = 1'b1;  // gone next edge
		@(negedge clk);
		req.rready = 1'b0;
	endtask

	task automatic readStatus(output uartStatus_t st);
		logic [31:0] w;
		axiRead(`UART_REG_STATUS, w);
		st = uartStatus_t'(w[7:0]);
	endtask

	task automatic readChar(output rxChar_t ch);
		logic [31:0] w;
		axiRead(`UART_REG_DATA, w);
		ch = rxChar_t'(w[10:0]);
	endtask

	// ==================================================
	// expected values from the line rules
	// ==================================================
	function automatic logic [7:0] maskByte(input logic [7:0] d, input logic [3:0] wl);
		return d & ((8'd1 << wl) - 8'd1);  // wl 8 wraps to ff
	endfunction

	function automatic logic expParity(input parity_e p, input logic [7:0] d);
		case (p)
			PAR_ODD:   return ~^d;
			PAR_EVEN:  return ^d;
			PAR_MARK:  return 1'b1;
			default:   return 1'b0;  // space
		endcase
	endfunction

	function automatic int buildFrame(input stim_t s, output logic [11:0] bits);
		int n;
		logic [7:0] d;
		d = maskByte(s.data, s.wl);
		bits = '1;
		bits[0] = 1'b0;  // start
		n = 1;
		for (int i = 0; i < int'(s.wl); i++) begin
			bits[n] = d[i];
			n++;
		end
		if (s.par inside {PAR_ODD, PAR_EVEN, PAR_MARK, PAR_SPACE}) begin
			bits[n] = expParity(s.par, d);
			n++;
		end
		n += s.twoStop ? 2 : 1;  // stop bits already ones
		return n;
	endfunction

	function automatic logic [31:0] ctrlWord(input logic [3:0] wl, input parity_e par,
			input logic twoStop, input logic brk);
		return {23'd0, wl, par, twoStop, brk};
	endfunction

	task automatic finishTest(input string name, input int errBefore);
		testsRun++;
		if (errCount == errBefore)
			$display("test %s: ok", name);
		else begin
			testsFailed++;
			$display("test %s: failed with %0d errors", name, errCount - errBefore);
		end
	endtask

	// wait at negedges for txd low, 0 on timeout
	task automatic waitTxdLow(input int limit, output logic seen);
		seen = 1'b0;
		for (int i = 0; i < limit && !seen; i++) begin
			@(negedge clk);
			seen = !txd;
		end
	endtask

	task automatic holdCheck(input logic level, input int clocks, input string what);
		int bad;
		bad = 0;
		repeat (clocks) begin
			@(negedge clk);
			if (txd !== level)
				bad++;
		end
		if (bad != 0) begin
			$display("txd did not stay %0d %s", level, what);
			errCount++;
		end
	endtask

	task automatic sendRaw(input logic [11:0] bits, input int n, input int bitClocks);
		for (int i = 0; i < n; i++) begin
			lineDrive = bits[i];
			repeat (bitClocks) @(negedge clk);
		end
		lineDrive = 1'b1;
		repeat (2 * bitClocks) @(negedge clk);  // idle after the frame
	endtask

	// ==================================================
	// one table entry: framing and loopback
	// ==================================================
	task automatic runFrame(input stim_t s, input int idx);
		int errBefore;
		int bitClocks;
		int n;
		int polls;
		logic [11:0] bits;
		logic seen;
		uartStatus_t st;
		rxChar_t ch;
		rxChar_t expCh;
		errBefore = errCount;
		bitClocks = TPB * (int'(s.div) + 1);
		n = buildFrame(s, bits);
		axiWrite(`UART_REG_BAUD, {16'd0, s.div});
		axiWrite(`UART_REG_CTRL, ctrlWord(s.wl, s.par, s.twoStop, 1'b0));
		cts = s.cts;
		axiWrite(`UART_REG_DATA, {24'd0, s.data});
		if (!s.cts) begin
			holdCheck(1'b1, 2 * bitClocks, "while cts is low");
			cts = 1'b1;
		end
		waitTxdLow(4 * bitClocks, seen);
		if (!seen) begin
			$display("entry %0d: no start bit on txd", idx);
			errCount++;
		end else begin
			repeat (bitClocks / 2) @(negedge clk);  // to mid start bit
			checkBit($sformatf("txd bit 0 entry %0d", idx), txd, bits[0]);
			for (int i = 1; i < n; i++) begin
				repeat (bitClocks) @(negedge clk);
				checkBit($sformatf("txd bit %0d entry %0d", i, idx), txd, bits[i]);
			end
		end
		polls = 0;
		readStatus(st);
		while ((st.txBusy || st.rxEmpty) && polls < 200) begin
			readStatus(st);
			polls++;
		end
		if (st.rxEmpty) begin
			$display("entry %0d: nothing received on loopback", idx);
			errCount++;
		end else begin
			readChar(ch);
			expCh = '{breakDet: 1'b0, frameErr: 1'b0, parityErr: 1'b0,
				data: maskByte(s.data, s.wl)};
			checkChar($sformatf("rxChar entry %0d", idx), ch, expCh);
		end
		finishTest($sformatf("frame %0d", idx), errBefore);
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		logic [31:0] w;
		int errBefore;
		int frames;
		logic seen;
		uartStatus_t st;
		uartStatus_t expSt;
		rxChar_t ch;

		clk = 1'b0;
		rst = 1'b1;
		cts = 1'b1;
		lineDrive = 1'b1;
		req = '0;  // bready and rready raised per response
		errCount = 0;
		testsRun = 0;
		testsFailed = 0;
		void'($urandom(32'hc823));

		stimTable[0] = '{wl: 4'd8, par: PAR_NONE,  twoStop: 1'b0, div: 16'd0, data: 8'h55, cts: 1'b1};
		stimTable[1] = '{wl: 4'd7, par: PAR_EVEN,  twoStop: 1'b0, div: 16'd1, data: 8'($urandom),
			cts: 1'b1};
		stimTable[2] = '{wl: 4'd5, par: PAR_ODD,   twoStop: 1'b1, div: 16'd0, data: 8'($urandom),
			cts: 1'b1};
		stimTable[3] = '{wl: 4'd6, par: PAR_MARK,  twoStop: 1'b0, div: 16'd2, data: 8'($urandom),
			cts: 1'b0};
		stimTable[4] = '{wl: 4'd8, par: PAR_SPACE, twoStop: 1'b1, div: 16'd3, data: 8'hA3, cts: 1'b1};
		stimTable[5] = '{wl: 4'd8, par: PAR_ODD,   twoStop: 1'b0, div: 16'd0, data: 8'($urandom),
			cts: 1'b0};
		stimTable[6] = '{wl: 4'd7, par: PAR_NONE,  twoStop: 1'b1, div: 16'd1, data: 8'h80, cts: 1'b1};
		stimTable[7] = '{wl: 4'd5, par: PAR_EVEN,  twoStop: 1'b0, div: 16'd3, data: 8'($urandom),
			cts: 1'b1};

		repeat (10) @(negedge clk);
		rst = 1'b0;

		// register access
		errBefore = errCount;
		readStatus(st);
		expSt = '0;
		expSt.txEmpty = 1'b1;
		expSt.rxEmpty = 1'b1;
		checkStatus("status after reset", st, expSt);
		axiWrite(`UART_REG_CTRL, ctrlWord(4'd6, PAR_ODD, 1'b1, 1'b0));
		axiRead(`UART_REG_CTRL, w);
		checkWord("ctrl readback", w, ctrlWord(4'd6, PAR_ODD, 1'b1, 1'b0));
		axiWrite(`UART_REG_BAUD, 32'(SLOW_DIV));
		axiRead(`UART_REG_BAUD, w);
		checkWord("baud readback", w, 32'(SLOW_DIV));
		axiWrite(`UART_REG_BAUD, 32'd0);
		repeat (SLOW_DIV + 20) @(negedge clk);  // old divisor runs out
		finishTest("register access", errBefore);

		for (int i = 0; i < TABLE_LEN; i++)
			runFrame(stimTable[i], i);

		// error detection, rxd driven by the testbench
		errBefore = errCount;
		axiWrite(`UART_REG_BAUD, 32'd0);
		axiWrite(`UART_REG_CTRL, ctrlWord(4'd8, PAR_EVEN, 1'b0, 1'b0));
		repeat (8 * TPB) @(negedge clk);
		force lineWire = lineDrive;
		sendRaw({1'b1, 1'b0, 8'h01, 1'b0}, 11, TPB);  // parity should be 1
		readChar(ch);
		checkChar("rxChar bad parity", ch,
			'{breakDet: 1'b0, frameErr: 1'b0, parityErr: 1'b1, data: 8'h01});
		sendRaw({1'b0, 1'b0, 8'h55, 1'b0}, 11, TPB);  // stop low
		readChar(ch);
		checkChar("rxChar low stop", ch,
			'{breakDet: 1'b0, frameErr: 1'b1, parityErr: 1'b0, data: 8'h55});
		readStatus(st);
		expSt = '0;
		expSt.txEmpty = 1'b1;
		expSt.rxEmpty = 1'b1;
		expSt.parityErr = 1'b1;
		expSt.frameErr = 1'b1;
		checkStatus("status sticky errors", st, expSt);
		sendRaw(12'h000, 11, TPB);  // break
		readStatus(st);
		expSt = '0;
		expSt.txEmpty = 1'b1;
		expSt.frameErr = 1'b1;
		checkStatus("status on break", st, expSt);
		readChar(ch);
		checkChar("rxChar break", ch,
			'{breakDet: 1'b1, frameErr: 1'b1, parityErr: 1'b0, data: 8'h00});
		release lineWire;
		readStatus(st);  // drop the sticky frame bit
		finishTest("error detection", errBefore);

		// fifo limits and flow control
		errBefore = errCount;
		axiWrite(`UART_REG_CTRL, ctrlWord(4'd8, PAR_NONE, 1'b0, 1'b0));
		cts = 1'b0;
		for (int i = 0; i <= DEPTH; i++)
			axiWrite(`UART_REG_DATA, 32'h30 + i);
		readStatus(st);
		expSt = '0;
		expSt.txFull = 1'b1;
		expSt.rxEmpty = 1'b1;
		checkStatus("status tx full", st, expSt);
		holdCheck(1'b1, 4 * TPB, "with cts low and bytes queued");
		cts = 1'b1;
		frames = 0;
		seen = 1'b1;
		while (seen && frames < 2 * DEPTH) begin
			waitTxdLow(3 * TPB, seen);
			if (seen) begin
				frames++;
				repeat (9 * TPB + TPB / 2) @(negedge clk);  // into the stop bit
			end
		end
		checkWord("frames sent", frames, DEPTH);
		readStatus(st);
		expSt = '0;
		expSt.txEmpty = 1'b1;
		expSt.rxFull = 1'b1;
		checkStatus("status rx full", st, expSt);
		axiWrite(`UART_REG_DATA, 32'h5A);  // one past the rx fifo
		repeat (14 * TPB) @(negedge clk);
		readStatus(st);
		expSt.overrun = 1'b1;
		checkStatus("status overrun", st, expSt);
		// the queued bytes in order, the ninth and the overrun byte lost
		for (int i = 0; i < DEPTH; i++) begin
			readChar(ch);
			checkByte($sformatf("rx data %0d", i), ch.data, 8'h30 + 8'(i));
		end
		axiWrite(`UART_REG_CTRL, ctrlWord(4'd8, PAR_NONE, 1'b0, 1'b0) | (32'd1 << `UART_CTRL_RXCLR));
		readStatus(st);
		expSt = '0;
		expSt.txEmpty = 1'b1;
		expSt.rxEmpty = 1'b1;
		checkStatus("status after rx clear", st, expSt);
		finishTest("fifo limits", errBefore);

		// break and transmit clear
		errBefore = errCount;
		axiWrite(`UART_REG_CTRL, ctrlWord(4'd8, PAR_NONE, 1'b0, 1'b1));
		waitTxdLow(TPB + 4, seen);
		if (!seen) begin
			$display("txd did not go low within one bit time of break");
			errCount++;
		end
		holdCheck(1'b0, 3 * TPB, "during break");
		axiWrite(`UART_REG_CTRL, ctrlWord(4'd8, PAR_NONE, 1'b0, 1'b0));
		repeat (24 * TPB) @(negedge clk);  // break frames drain
		cts = 1'b0;
		for (int i = 0; i < 3; i++)
			axiWrite(`UART_REG_DATA, 32'hC0 + i);
		readStatus(st);
		checkBit("txEmpty with bytes queued", st.txEmpty, 1'b0);
		axiWrite(`UART_REG_CTRL, ctrlWord(4'd8, PAR_NONE, 1'b0, 1'b0)
			| (32'd1 << `UART_CTRL_TXCLR) | (32'd1 << `UART_CTRL_RXCLR));
		readStatus(st);
		checkStatus("status after clear", st, expSt);
		finishTest("break and clear", errBefore);

		$display("tests %0d, failed %0d, check errors %0d", testsRun, testsFailed, errCount);
		if (errCount == 0 && testsFailed == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- files.f
+incdir+include
verilog/uartBusPkg.sv
verilog/uartLinePkg.sv
verilog/uartFifo.sv
verilog/uartBaudGen.sv
verilog/uartTx.sv
verilog/uartRx.sv
verilog/uartRegs.sv
verilog/uartTop.sv
verif/uartProps.sv
verif/uartTb.sv

//--- Makefile
TOP := uartTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f files.f --top-module $(TOP) -o $(TOP)

# grep sets the exit status of the whole pipe
run: build
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "^=== PASS ===$$"

lint:
	verilator --lint-only --timing -f files.f --top-module uartTop

clean:
	rm -rf obj_dir
